// ==== hdl/quirk_table.svh ====
// Header titles of games that need quirks, and their flags
`ifndef QUIRK_TABLE_SVH
`define QUIRK_TABLE_SVH

// First character in the top byte, padded with zero bytes to the title length
localparam logic [cart_pkg::HDR_TITLE_LEN*8-1:0] QUIRK_TITLE [QUIRK_COUNT] = '{
	{"ROCKY BOXING"},                     // Rocky US
	{"ROCKY", 56'h0},                     // Rocky EU
	{"DBZ LGCYGOKU"},                     // Legacy of Goku US
	{"DBZ TAIKETSU"},
	{"TOPGUN CZ", 24'h0},
	{"IRIDIONII", 24'h0},                 // Same title in EU and US
	{"BOMBER MAN", 16'h0},                // Classic NES ports from here on
	{"CASTLEVANIA", 8'h0},
	{"PAC-MAN", 40'h0},
	{"MAPPY", 56'h0}
};

// Same order as the titles
localparam cart_pkg::quirk_t QUIRK_FLAGS [QUIRK_COUNT] = '{
	'{sram: 1'b1, remap: 1'b0},
	'{sram: 1'b1, remap: 1'b0},
	'{sram: 1'b1, remap: 1'b0},
	'{sram: 1'b1, remap: 1'b0},
	'{sram: 1'b1, remap: 1'b0},
	'{sram: 1'b1, remap: 1'b0},
	'{sram: 1'b1, remap: 1'b1},           // NES ports need both
	'{sram: 1'b1, remap: 1'b1},
	'{sram: 1'b1, remap: 1'b1},
	'{sram: 1'b1, remap: 1'b1}
};

`endif

// ==== hdl/loader_pkg.sv ====
// Host download stream widths, index codes and transfer kinds
// Halfword slot offsets of a cheat record
`default_nettype none

package loader_pkg;

	localparam int IOCTL_ADDR_W = 27;          // Byte address of the host stream
	localparam int IOCTL_DATA_W = 16;          // One halfword per write strobe
	localparam int INDEX_W      = 8;

	localparam logic [INDEX_W-1:0] INDEX_CHEAT = 8'd255;   // Cheat file
	localparam logic [INDEX_W-1:0] INDEX_BIOS  = 8'd0;     // Firmware image

	// Kind of the running transfer, taken from the index
	typedef enum logic [1:0] {
		DL_NONE  = 2'd0,                       // No download in progress
		DL_BIOS  = 2'd1,
		DL_CART  = 2'd2,                       // Any index that is not firmware or cheat
		DL_CHEAT = 2'd3
	} dl_kind_t;

	// Byte offset of each halfword inside a 16-byte cheat record
	typedef enum logic [3:0] {
		SLOT_FLAGS_LO = 4'd0,
		SLOT_FLAGS_HI = 4'd2,
		SLOT_ADDR_LO  = 4'd4,
		SLOT_ADDR_HI  = 4'd6,
		SLOT_CMP_LO   = 4'd8,
		SLOT_CMP_HI   = 4'd10,
		SLOT_REPL_LO  = 4'd12,
		SLOT_REPL_HI  = 4'd14                  // Last halfword, closes the record
	} cheat_slot_t;

endpackage

`default_nettype wire

// ==== hdl/cart_pkg.sv ====
// Cartridge header layout, flash signature text and quirk flag type
`default_nettype none

package cart_pkg;

	// ====================================================================
	// Header title
	// ====================================================================

	// Title sits at byte 0xA0, so byte address bits 26:4 equal 0xA
	localparam logic [22:0] HDR_TITLE_BASE = 23'h00000A;

	localparam int HDR_TITLE_LEN = 12;        // Bytes, zero padded

	// ====================================================================
	// Flash signature
	// ====================================================================

	localparam int FLASH_SIG_LEN = 9;

	// 1-Mbit flash carts carry this text somewhere in the image
	localparam logic [FLASH_SIG_LEN*8-1:0] FLASH_SIG = "FLASH1M_V";

	// ====================================================================
	// Quirks
	// ====================================================================

	typedef struct packed {
		logic sram;                           // Backup RAM access quirk
		logic remap;                          // Memory remap quirk of the NES ports
	} quirk_t;

	localparam int QUIRK_COUNT = 10;          // Entries in the title table

endpackage

`default_nettype wire

// ==== hdl/ioctl_decode.sv ====
// Download classification by index
// Cartridge start and end pulses, cheat clear pulse
`timescale 1ns/1ns
`default_nettype none

module ioctl_decode (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               ioctl_download,
	input  logic [loader_pkg::INDEX_W-1:0]     ioctl_index,
	output loader_pkg::dl_kind_t               dl_kind,
	output logic                               cart_start,
	output logic                               cart_end,
	output logic                               cheat_clear
);

	loader_pkg::dl_kind_t kind_next;          // Kind seen at the inputs this cycle
	logic download_r;                         // Download level, in step with dl_kind
	logic download_q;                         // Previous download_r
	logic cart_lvl;
	logic cart_q;                             // Previous cartridge level

	// Index to transfer kind
	always_comb begin
		if (!ioctl_download)
			kind_next = loader_pkg::DL_NONE;
		else if (ioctl_index == loader_pkg::INDEX_CHEAT)
			kind_next = loader_pkg::DL_CHEAT;
		else if (ioctl_index == loader_pkg::INDEX_BIOS)
			kind_next = loader_pkg::DL_BIOS;
		else
			kind_next = loader_pkg::DL_CART;
	end

	assign cart_lvl = (dl_kind == loader_pkg::DL_CART);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_kind     <= loader_pkg::DL_NONE;
			download_r  <= 1'b0;
			download_q  <= 1'b0;
			cart_q      <= 1'b0;
			cart_start  <= 1'b0;
			cart_end    <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			dl_kind    <= kind_next;
			download_r <= ioctl_download;
			download_q <= download_r;
			cart_q     <= cart_lvl;
			cart_start <= cart_lvl & ~cart_q;     // Rising edge of the cart level
			cart_end   <= ~cart_lvl & cart_q;
			// One clear per cheat file, on the download rise
			cheat_clear <= download_r & ~download_q & (dl_kind == loader_pkg::DL_CHEAT);
		end
	end

	// Host keeps the index steady for the whole transfer
	a_index_stable: assert property (@(posedge clk_sys) disable iff (reset)
		download_r && ioctl_download |-> $stable(ioctl_index))
		else $error("ioctl_index changed during a download");

endmodule

`default_nettype wire

// ==== hdl/cart_probe.sv ====
// Cartridge type, loaded flag and last byte address
// Scan of the image for the 1-Mbit flash signature
`timescale 1ns/1ns
`default_nettype none

module cart_probe (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  loader_pkg::dl_kind_t                  dl_kind,
	input  logic                                  cart_start,
	input  logic                                  cart_end,
	input  logic                                  ioctl_wr,
	input  logic [loader_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  logic [loader_pkg::IOCTL_DATA_W-1:0]   ioctl_dout,
	input  logic [loader_pkg::INDEX_W-1:0]        ioctl_index,
	output logic                                  cart_loaded,
	output logic                                  flash_1m,
	output logic                                  force_turbo,
	output logic [1:0]                            cart_type,
	output logic [loader_pkg::IOCTL_ADDR_W-1:0]   last_addr
);

	localparam int SIG_W  = cart_pkg::FLASH_SIG_LEN * 8;  // 72 bits of text
	localparam int HIST_W = SIG_W - 8;                    // All but the newest byte

	logic [HIST_W-1:0] history;               // Received bytes, newest in the low byte
	logic cart_wr;
	logic sig_at_low;                         // Signature ends on the low byte
	logic sig_at_high;                        // Signature ends on the high byte

	assign cart_wr = ioctl_wr && (dl_kind == loader_pkg::DL_CART);

	// ====================================================================
	// Flash signature scan
	// ====================================================================

	// Low byte of a halfword comes first in the image
	assign sig_at_low  = ({history, ioctl_dout[7:0]} == cart_pkg::FLASH_SIG);
	assign sig_at_high = ({history[HIST_W-9:0], ioctl_dout[7:0], ioctl_dout[15:8]}
		== cart_pkg::FLASH_SIG);

	always_ff @(posedge clk_sys) begin
		if (cart_start)
			history <= '0;                        // No match across two images
		else if (cart_wr)
			history <= {history[HIST_W-17:0], ioctl_dout[7:0], ioctl_dout[15:8]};
	end

	// ====================================================================
	// Cartridge status
	// ====================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type   <= 2'b00;
			cart_loaded <= 1'b0;
			flash_1m    <= 1'b0;
			force_turbo <= 1'b0;
			last_addr   <= '0;
		end else begin
			force_turbo <= |cart_type;            // Any non-GBA cart type runs in turbo
			if (cart_start) begin
				cart_type   <= ioctl_index[loader_pkg::INDEX_W-1 -: 2];
				cart_loaded <= 1'b1;
				flash_1m    <= 1'b0;
			end
			if (cart_wr && (sig_at_low || sig_at_high))
				flash_1m <= 1'b1;
			if (cart_end)
				last_addr <= ioctl_addr;              // Host still holds the final address
		end
	end

endmodule

`default_nettype wire

// ==== hdl/quirk_match.sv ====
// Header title capture and match against the quirk table
`timescale 1ns/1ns
`default_nettype none

module quirk_match #(
	parameter int QUIRK_COUNT = cart_pkg::QUIRK_COUNT
) (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  loader_pkg::dl_kind_t                  dl_kind,
	input  logic                                  cart_start,
	input  logic                                  ioctl_wr,
	input  logic [loader_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  logic [loader_pkg::IOCTL_DATA_W-1:0]   ioctl_dout,
	output logic                                  sram_quirk,
	output logic                                  memory_remap_quirk
);

	`include "quirk_table.svh"

	localparam int TITLE_W = cart_pkg::HDR_TITLE_LEN * 8;
	localparam logic [3:0] DONE_OFS = 4'(cart_pkg::HDR_TITLE_LEN);  // First byte after title

	logic [TITLE_W-1:0] title;                // First title byte in the top byte
	logic               title_win;            // Write lands in the 16-byte header line
	logic [2:0]         half_idx;             // Halfword number inside the title
	cart_pkg::quirk_t   hit;

	assign title_win = ioctl_wr && (dl_kind == loader_pkg::DL_CART)
		&& (ioctl_addr[loader_pkg::IOCTL_ADDR_W-1:4] == cart_pkg::HDR_TITLE_BASE);
	assign half_idx = ioctl_addr[3:1];

	// Byte swapped so the text reads in order from the top
	always_ff @(posedge clk_sys) begin
		if (title_win && (ioctl_addr[3:0] < DONE_OFS))
			title[TITLE_W-16 - half_idx*16 +: 16] <= {ioctl_dout[7:0], ioctl_dout[15:8]};
	end

	// OR of the flags of every matching entry
	always_comb begin
		hit = '0;
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			if (title == QUIRK_TITLE[i]) begin
				hit.sram  = hit.sram | QUIRK_FLAGS[i].sram;
				hit.remap = hit.remap | QUIRK_FLAGS[i].remap;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset || cart_start) begin
			sram_quirk         <= 1'b0;
			memory_remap_quirk <= 1'b0;
		end else if (title_win && (ioctl_addr[3:0] == DONE_OFS)) begin
			sram_quirk         <= hit.sram;       // Title complete by now
			memory_remap_quirk <= hit.remap;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bios_packer.sv ====
// Firmware halfwords packed into 32-bit words with a write pulse
`timescale 1ns/1ns
`default_nettype none

module bios_packer #(
	parameter int BIOS_AW = 12                // Word address width of the firmware RAM
) (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  loader_pkg::dl_kind_t                  dl_kind,
	input  logic                                  ioctl_wr,
	input  logic [loader_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  logic [loader_pkg::IOCTL_DATA_W-1:0]   ioctl_dout,
	output logic [BIOS_AW-1:0]                    bios_wraddr,
	output logic [2*loader_pkg::IOCTL_DATA_W-1:0] bios_wrdata,
	output logic                                  bios_wr
);

	logic bios_hw_wr;                         // Firmware halfword this cycle
	logic odd_half;                           // Upper half of a word

	assign bios_hw_wr = ioctl_wr && (dl_kind == loader_pkg::DL_BIOS);
	assign odd_half   = ioctl_addr[1];

	always_ff @(posedge clk_sys) begin
		if (bios_hw_wr) begin
			if (!odd_half)
				bios_wrdata[15:0] <= ioctl_dout;
			else begin
				bios_wrdata[31:16] <= ioctl_dout;
				bios_wraddr        <= ioctl_addr[BIOS_AW+1:2];  // Byte to word address
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= bios_hw_wr & odd_half;     // Word complete
	end

	// Halfwords alternate even and odd, so words never arrive back to back
	a_wr_spaced: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr |=> !bios_wr)
		else $error("bios_wr high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== hdl/cheat_assembler.sv ====
// 128-bit cheat code assembly from the halfwords of a cheat file
`timescale 1ns/1ns
`default_nettype none

module cheat_assembler (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  loader_pkg::dl_kind_t                  dl_kind,
	input  logic                                  ioctl_wr,
	input  logic [loader_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  logic [loader_pkg::IOCTL_DATA_W-1:0]   ioctl_dout,
	output logic [127:0]                          cheat_code,
	output logic                                  cheat_valid
);

	logic                    cheat_wr;
	loader_pkg::cheat_slot_t slot;

	assign cheat_wr = ioctl_wr && (dl_kind == loader_pkg::DL_CHEAT);
	assign slot     = loader_pkg::cheat_slot_t'(ioctl_addr[3:0]);

	// Record layout is {flags, address, compare, replace}, low halfword first
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (slot)
				loader_pkg::SLOT_FLAGS_LO: cheat_code[111:96]  <= ioctl_dout;
				loader_pkg::SLOT_FLAGS_HI: cheat_code[127:112] <= ioctl_dout;
				loader_pkg::SLOT_ADDR_LO:  cheat_code[79:64]   <= ioctl_dout;
				loader_pkg::SLOT_ADDR_HI:  cheat_code[95:80]   <= ioctl_dout;
				loader_pkg::SLOT_CMP_LO:   cheat_code[47:32]   <= ioctl_dout;
				loader_pkg::SLOT_CMP_HI:   cheat_code[63:48]   <= ioctl_dout;
				loader_pkg::SLOT_REPL_LO:  cheat_code[15:0]    <= ioctl_dout;
				loader_pkg::SLOT_REPL_HI:  cheat_code[31:16]   <= ioctl_dout;
				default: ;                            // Odd offsets never come
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= cheat_wr && (slot == loader_pkg::SLOT_REPL_HI);  // Record done
	end

	// Cheat records arrive as whole halfwords on even byte offsets
	a_even_slot: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_wr |-> !ioctl_addr[0])
		else $error("cheat write at an odd byte offset");

endmodule

`default_nettype wire

// ==== hdl/gba_loader.sv ====
// Cartridge and firmware loader top level
// Download decode, cart probe, quirk match, firmware packer, cheat assembler
`timescale 1ns/1ns
`default_nettype none

module gba_loader #(
	parameter int BIOS_AW = 12
) (
	input  logic                                  clk_sys,
	input  logic                                  reset,

	// Host download stream
	input  logic                                  ioctl_download,
	input  logic [loader_pkg::INDEX_W-1:0]        ioctl_index,
	input  logic [loader_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  logic [loader_pkg::IOCTL_DATA_W-1:0]   ioctl_dout,
	input  logic                                  ioctl_wr,

	// Cartridge status
	output logic [1:0]                            cart_type,
	output logic                                  cart_loaded,
	output logic                                  flash_1m,
	output logic                                  force_turbo,
	output logic [loader_pkg::IOCTL_ADDR_W-1:0]   last_addr,
	output logic                                  sram_quirk,
	output logic                                  memory_remap_quirk,

	// Firmware RAM write port
	output logic [BIOS_AW-1:0]                    bios_wraddr,
	output logic [2*loader_pkg::IOCTL_DATA_W-1:0] bios_wrdata,
	output logic                                  bios_wr,

	// Cheat engine
	output logic [127:0]                          cheat_code,
	output logic                                  cheat_valid,
	output logic                                  cheat_clear
);

	loader_pkg::dl_kind_t dl_kind;            // Registered transfer kind
	logic                 cart_start;
	logic                 cart_end;

	ioctl_decode u_decode (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.dl_kind(dl_kind), .cart_start(cart_start), .cart_end(cart_end),
		.cheat_clear(cheat_clear)
	);

	cart_probe u_probe (
		.clk_sys(clk_sys), .reset(reset), .dl_kind(dl_kind),
		.cart_start(cart_start), .cart_end(cart_end),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_index(ioctl_index),
		.cart_loaded(cart_loaded), .flash_1m(flash_1m), .force_turbo(force_turbo),
		.cart_type(cart_type), .last_addr(last_addr)
	);

	quirk_match #(.QUIRK_COUNT(cart_pkg::QUIRK_COUNT)) u_quirk (
		.clk_sys(clk_sys), .reset(reset), .dl_kind(dl_kind), .cart_start(cart_start),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.sram_quirk(sram_quirk), .memory_remap_quirk(memory_remap_quirk)
	);

	bios_packer #(.BIOS_AW(BIOS_AW)) u_bios (
		.clk_sys(clk_sys), .reset(reset), .dl_kind(dl_kind),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.bios_wraddr(bios_wraddr), .bios_wrdata(bios_wrdata), .bios_wr(bios_wr)
	);

	cheat_assembler u_cheat (
		.clk_sys(clk_sys), .reset(reset), .dl_kind(dl_kind),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.cheat_code(cheat_code), .cheat_valid(cheat_valid)
	);

endmodule

`default_nettype wire

// ==== test/tb_gba_loader.sv ====
// Testbench for the loader top level, replays the stimulus file against the DUT
// Pulse monitors capture firmware words, cheat records and cheat clears
`timescale 1ns/1ns
`default_nettype none

module tb_gba_loader;

	localparam int    BIOS_AW   = 12;
	localparam int    AW        = loader_pkg::IOCTL_ADDR_W;
	localparam string STIM_FILE = "test/loader_stimulus.txt";

	logic                              clk_sys = 1'b0;
	logic                              reset;
	logic                              ioctl_download;
	logic [loader_pkg::INDEX_W-1:0]    ioctl_index;
	logic [AW-1:0]                     ioctl_addr;
	logic [loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout;
	logic                              ioctl_wr;

	logic [1:0]         cart_type;
	logic               cart_loaded, flash_1m, force_turbo;
	logic [AW-1:0]      last_addr;
	logic               sram_quirk, memory_remap_quirk;
	logic [BIOS_AW-1:0] bios_wraddr;
	logic [31:0]        bios_wrdata;
	logic               bios_wr;
	logic [127:0]       cheat_code;
	logic               cheat_valid, cheat_clear;

	// Captured pulses, read back in order by the checks
	logic [BIOS_AW-1:0] bios_addr_q[$];
	logic [31:0]        bios_data_q[$];
	logic [127:0]       cheat_code_q[$];
	int bios_total = 0;                       // Pulse totals since time zero
	int cheat_total = 0;
	int clear_total = 0;
	int bios_base = 0;                        // Totals at the last download start
	int cheat_base = 0;
	int clear_base = 0;
	int bios_addr_rd = 0;
	int bios_data_rd = 0;
	int cheat_rd = 0;

	int error_count = 0;
	int check_total = 0;
	int line_count = 0;
	int fd, code;
	bit done = 1'b0;
	logic [8*128-1:0] line_buf;
	logic [8*16-1:0]  op_buf, name_buf;
	logic [127:0]     arg_a, arg_b;
	string            op;

	gba_loader #(.BIOS_AW(BIOS_AW)) uut (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
		.cart_type(cart_type), .cart_loaded(cart_loaded), .flash_1m(flash_1m),
		.force_turbo(force_turbo), .last_addr(last_addr),
		.sram_quirk(sram_quirk), .memory_remap_quirk(memory_remap_quirk),
		.bios_wraddr(bios_wraddr), .bios_wrdata(bios_wrdata), .bios_wr(bios_wr),
		.cheat_code(cheat_code), .cheat_valid(cheat_valid), .cheat_clear(cheat_clear)
	);

	always #10 clk_sys = ~clk_sys;            // 20 ns period

	// ====================================================================
	// Pulse monitor
	// ====================================================================

	always @(posedge clk_sys) begin
		if (!reset && bios_wr) begin
			bios_addr_q.push_back(bios_wraddr);   // Address and data belong to the pulse cycle
			bios_data_q.push_back(bios_wrdata);
			bios_total++;
		end
		if (!reset && cheat_valid) begin
			cheat_code_q.push_back(cheat_code);
			cheat_total++;
		end
		if (!reset && cheat_clear)
			clear_total++;
	end

	// ====================================================================
	// Checks
	// ====================================================================

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED %s expected %0h actual %0h at %0t ns",
				name, expected, actual, $time);
		end
	endtask

	task automatic report_missing(input string name);
		error_count++;                        // Expected pulse never came
		$display("No captured pulse left for the %s check at %0t ns", name, $time);
	endtask

	// Levels sampled mid-cycle, pulse values taken from the capture queues
	task automatic run_check(input logic [8*16-1:0] key, input logic [127:0] expected);
		string name;
		name = $sformatf("%0s", key);
		@(negedge clk_sys);
		case (key)
			"cart_type":   check_value(name, expected, 128'(cart_type));
			"cart_loaded": check_value(name, expected, 128'(cart_loaded));
			"flash_1m":    check_value(name, expected, 128'(flash_1m));
			"force_turbo": check_value(name, expected, 128'(force_turbo));
			"last_addr":   check_value(name, expected, 128'(last_addr));
			"sram_quirk":  check_value(name, expected, 128'(sram_quirk));
			"remap_quirk": check_value(name, expected, 128'(memory_remap_quirk));
			"bios_wr":     check_value(name, expected, 128'(bios_wr));
			"cheat_valid": check_value(name, expected, 128'(cheat_valid));
			"cheat_clear": check_value(name, expected, 128'(cheat_clear));
			"bios_count":  check_value(name, expected, 128'(bios_total - bios_base));
			"cheat_count": check_value(name, expected, 128'(cheat_total - cheat_base));
			"clear_count": check_value(name, expected, 128'(clear_total - clear_base));
			"bios_addr": begin
				if (bios_addr_rd < bios_addr_q.size()) begin
					check_value(name, expected, 128'(bios_addr_q[bios_addr_rd]));
					bios_addr_rd++;
				end else
					report_missing(name);
			end
			"bios_data": begin
				if (bios_data_rd < bios_data_q.size()) begin
					check_value(name, expected, 128'(bios_data_q[bios_data_rd]));
					bios_data_rd++;
				end else
					report_missing(name);
			end
			"cheat_code": begin
				if (cheat_rd < cheat_code_q.size()) begin
					check_value(name, expected, cheat_code_q[cheat_rd]);
					cheat_rd++;
				end else
					report_missing(name);
			end
			default: begin
				error_count++;
				$display("Unknown check name %s in the stimulus file", name);
			end
		endcase
	endtask

	// ====================================================================
	// Host stream operations
	// ====================================================================

	task automatic start_download(input logic [7:0] index);
		@(negedge clk_sys);
		bios_base  = bios_total;              // Counts restart with every download
		cheat_base = cheat_total;
		clear_base = clear_total;
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		repeat (4) @(posedge clk_sys);        // First write no sooner than 4 cycles later
	endtask

	task automatic write_halfword(input logic [AW-1:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;                   // Strobe is one cycle, address stays
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (6) @(posedge clk_sys);        // End pulse and last address settle
	endtask

	// ====================================================================
	// Stimulus replay
	// ====================================================================

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			error_count++;
			$display("Cannot open the stimulus file %s", STIM_FILE);
		end else begin
			while ($fgets(line_buf, fd) > 0)
				line_count++;                     // Sizes the watchdog
			$fclose(fd);
			fd = $fopen(STIM_FILE, "r");
			repeat (3) @(posedge clk_sys);
			reset <= 1'b0;
			while (!done) begin
				code = $fscanf(fd, "%s", op_buf);
				op = $sformatf("%0s", op_buf);
				if (code != 1)
					done = 1'b1;                      // End of file
				else if (op_buf == "#")
					code = $fgets(line_buf, fd);      // Comment line
				else if (op_buf == "start") begin
					code = $fscanf(fd, "%h", arg_a);
					start_download(arg_a[7:0]);
				end else if (op_buf == "write") begin
					code = $fscanf(fd, "%h %h", arg_a, arg_b);
					write_halfword(arg_a[AW-1:0], arg_b[15:0]);
				end else if (op_buf == "wait") begin
					code = $fscanf(fd, "%h", arg_a);
					repeat (arg_a[15:0]) @(posedge clk_sys);
				end else if (op_buf == "end")
					end_download();
				else if (op_buf == "check") begin
					code = $fscanf(fd, "%s %h", name_buf, arg_a);
					run_check(name_buf, arg_a);
				end else begin
					error_count++;
					$display("Unknown operation %s in the stimulus file", op);
					code = $fgets(line_buf, fd);
				end
			end
			$fclose(fd);
			repeat (2) @(posedge clk_sys);
		end
		$display("Checks: %0d, errors: %0d", check_total, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog, ten cycles per stimulus line plus margin
	initial begin
		wait (line_count > 0);
		repeat (line_count * 10 + 100) @(posedge clk_sys);
		$display("Timeout, the stimulus replay did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/loader_stimulus.txt ====
# op args in hex: start index | write addr data | wait cycles | end | check name value
# check names: outputs, bios/cheat/clear_count pulses per download, bios_addr/bios_data/cheat_code next pulse
check cart_loaded 0
check flash_1m 0
check sram_quirk 0
check last_addr 0
check bios_wr 0
check cheat_valid 0
check cheat_clear 0
# Cartridge of type 1, last write at 0x100
start 40
check cart_type 1
check cart_loaded 1
check force_turbo 1
write 0 1234
write 2 5678
write 100 abcd
end
check last_addr 100
check flash_1m 0
# FLASH1M_V starting at odd byte 0x201
start 1
check cart_type 0
write 200 4600
write 202 414c
write 204 4853
write 206 4d31
check flash_1m 0
write 208 565f
check flash_1m 1
end
check last_addr 208
check force_turbo 0
# No signature, flash flag cleared at start
start 80
check flash_1m 0
check cart_type 2
write 200 4c46
end
check flash_1m 0
# Title BOMBER MAN, remap entry
start 40
write a0 4f42
write a2 424d
write a4 5245
write a6 4d20
write a8 4e41
write aa 0
write ac 96
check sram_quirk 1
check remap_quirk 1
end
# Title ROCKY, sram only
start 40
check sram_quirk 0
check remap_quirk 0
write a0 4f52
write a2 4b43
write a4 59
write a6 0
write a8 0
write aa 0
write ac 0
check sram_quirk 1
check remap_quirk 0
end
# Title ZELDA, not in the table
start 40
write a0 455a
write a2 444c
write a4 41
write a6 0
write a8 0
write aa 0
write ac 0
check sram_quirk 0
check remap_quirk 0
end
# Firmware, eight halfwords from byte 0x1000
start 0
write 1000 a001
write 1002 b002
write 1004 c003
write 1006 d004
write 1008 e005
write 100a f006
write 100c 0107
write 100e 0208
wait 2
check bios_count 4
check bios_addr 400
check bios_data b002a001
check bios_addr 401
check bios_data d004c003
check bios_addr 402
check bios_data f006e005
check bios_addr 403
check bios_data 02080107
end
# Cheat file with two records
start ff
check clear_count 1
write 0 0001
write 2 8000
write 4 1234
write 6 0300
write 8 00ff
write a 0000
write c 0063
write e 0000
write 10 0002
write 12 0000
write 14 5678
write 16 0200
write 18 beef
write 1a dead
write 1c cafe
write 1e f00d
wait 2
check cheat_count 2
check cheat_code 8000000103001234000000ff00000063
check cheat_code 0000000202005678deadbeeff00dcafe
end
check clear_count 1

// ==== src.f ====
+incdir+hdl
hdl/loader_pkg.sv
hdl/cart_pkg.sv
hdl/ioctl_decode.sv
hdl/cart_probe.sv
hdl/quirk_match.sv
hdl/bios_packer.sv
hdl/cheat_assembler.sv
hdl/gba_loader.sv
test/tb_gba_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the loader testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_gba_loader -Mdir obj_dir -o sim_tb_gba_loader

./obj_dir/sim_tb_gba_loader > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	echo "Testbench reported failure, see sim.log"
	exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
	echo "Simulation ended without a result, see sim.log"
	exit 1
fi
